/* flist.f */
core_pkg.sv
fetch.sv
decode.sv
regfile.sv
stage_reg.sv
exec.sv
core_top.sv
core_chk.sv
tb_monitor.sv
tb_core.sv

/* Makefile */
.PHONY: all run lint clean

all: run

obj_dir/Vtb_core: flist.f *.sv
	verilator --binary --timing --assert -f flist.f --top-module tb_core

run: obj_dir/Vtb_core
	./obj_dir/Vtb_core | tee sim.log
	grep -q "Everything OK" sim.log

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module tb_core

clean:
	rm -rf obj_dir sim.log

/* tb_core.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_core import core_pkg::*; ();

    localparam int PROG_LEN  = 27;
    localparam int NUM_TESTS = 3;
    localparam int NUM_STORE = 6;

    logic            CLK;
    logic            RST;
    logic            mmu_wait;
    logic [XLEN-1:0] inst_roaddr;
    logic            inst_rvalid;
    logic [XLEN-1:0] inst_rdata;
    logic            inst_rden;
    logic [XLEN-1:0] inst_riaddr;
    logic            data_wren;
    logic [XLEN-1:0] data_waddr;
    logic [XLEN-1:0] data_wdata;
    int              store_seen;
    int              error_count;

    logic [XLEN-1:0] prog [0:PROG_LEN-1];
    string           test_name [NUM_TESTS] = '{"plain", "random_wait", "slow_memory"};
    int              wait_pct  [NUM_TESTS] = '{0, 30, 0};
    int              max_lat   [NUM_TESTS] = '{1, 3, 3};
    logic [XLEN-1:0] exp_addr  [NUM_STORE] = '{32'h100, 32'h104, 32'h108,
                                             32'h10c, 32'h110, 32'h114};
    logic [XLEN-1:0] exp_data  [NUM_STORE] = '{32'h1234_5000, 32'h80, 32'h7f,
                                             32'hf0, 32'hf0, 32'h5c};

    int              cur_wait;
    int              cur_lat;
    int              cyc;
    int              lat;
    logic            next_wait;
    logic [XLEN-1:0] q_addr[$];
    int              q_due[$];

    core_top dut0 (
        .CLK(CLK), .RST(RST), .mmu_wait(mmu_wait),
        .inst_roaddr(inst_roaddr), .inst_rvalid(inst_rvalid), .inst_rdata(inst_rdata),
        .inst_rden(inst_rden), .inst_riaddr(inst_riaddr),
        .data_wren(data_wren), .data_waddr(data_waddr), .data_wdata(data_wdata)
    );

    tb_monitor mon0 (
        .CLK(CLK), .RST(RST), .mmu_wait(mmu_wait),
        .inst_rden(inst_rden), .inst_riaddr(inst_riaddr),
        .data_wren(data_wren), .data_waddr(data_waddr), .data_wdata(data_wdata),
        .store_seen(store_seen), .error_count(error_count)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    function automatic logic [31:0] enc_i(logic [6:0] op, logic [2:0] f3, int rd, int rs1,
                                          logic [31:0] imm);
        return {imm[11:0], 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [2:0] f3, int rd, int rs1,
                                          int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OPC_OP};
    endfunction

    function automatic logic [31:0] enc_s(int rs2, int rs1, logic [31:0] imm);
        return {imm[11:5], 5'(rs2), 5'(rs1), F3_SW, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_b(logic [2:0] f3, int rs1, int rs2, logic [31:0] imm);
        return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(int rd, logic [31:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), OPC_JAL};
    endfunction

    task automatic load_program();
        prog[0]  = {20'h12345, 5'd1, OPC_LUI};
        prog[1]  = enc_i(OPC_OP_IMM, F3_ADD_SUB, 2, 0, 32'h7f);
        prog[2]  = enc_i(OPC_OP_IMM, F3_ADD_SUB, 3, 2, 32'h1);
        prog[3]  = enc_s(1, 0, 32'h100);
        prog[4]  = enc_r(7'h00, F3_ADD_SUB, 4, 2, 3);
        prog[5]  = enc_r(7'h20, F3_ADD_SUB, 5, 4, 2);
        prog[6]  = enc_s(5, 0, 32'h104);
        prog[7]  = enc_i(OPC_OP_IMM, F3_XOR, 6, 4, 32'h0f);
        prog[8]  = enc_i(OPC_OP_IMM, F3_OR, 7, 6, 32'h300);
        prog[9]  = enc_i(OPC_OP_IMM, F3_AND, 8, 7, 32'h0f0);
        prog[10] = enc_r(7'h00, F3_AND, 9, 7, 4);
        prog[11] = enc_r(7'h00, F3_OR, 10, 6, 2);
        prog[12] = enc_r(7'h00, F3_XOR, 11, 10, 3);
        // base register x3 holds 0x80
        prog[13] = enc_s(11, 3, 32'h88);
        prog[14] = enc_i(OPC_OP_IMM, F3_ADD_SUB, 0, 0, 32'h5);
        prog[15] = enc_r(7'h00, F3_ADD_SUB, 12, 0, 9);
        prog[16] = enc_s(12, 0, 32'h10c);
        prog[17] = enc_b(F3_BEQ, 8, 9, 32'd12);
        prog[18] = enc_s(1, 0, 32'h1f0);
        prog[19] = enc_s(1, 0, 32'h1f4);
        prog[20] = enc_b(F3_BNE, 8, 9, 32'd8);
        prog[21] = enc_s(8, 0, 32'h110);
        prog[22] = enc_j(13, 32'd12);
        prog[23] = enc_s(1, 0, 32'h1f8);
        prog[24] = enc_s(1, 0, 32'h1fc);
        prog[25] = enc_s(13, 0, 32'h114);
        // park on a jump to itself
        prog[26] = enc_j(0, 32'd0);
    endtask

    function automatic logic [31:0] fetch_word(logic [31:0] addr);
        if ((addr >> 2) < PROG_LEN) begin
            return prog[addr >> 2];
        end
        return 32'h0000_0013;
    endfunction

    always @(posedge CLK) begin
        cyc <= cyc + 1;
    end

    // in-order instruction memory with random latency and stalls
    always @(posedge CLK) begin
        if (RST) begin
            q_addr.delete();
            q_due.delete();
            inst_rvalid <= 1'b0;
            mmu_wait    <= 1'b0;
        end else begin
            if (inst_rvalid && !mmu_wait) begin
                void'(q_addr.pop_front());
                void'(q_due.pop_front());
            end
            if (inst_rden && !mmu_wait) begin
                lat = 1 + int'($urandom % cur_lat);
                q_addr.push_back(inst_riaddr);
                q_due.push_back(cyc + lat - 1);
            end
            next_wait = int'($urandom % 100) < cur_wait;
            mmu_wait <= next_wait;
            if (!next_wait && q_addr.size() > 0 && q_due[0] <= cyc) begin
                inst_rvalid <= 1'b1;
                inst_roaddr <= q_addr[0];
                inst_rdata  <= fetch_word(q_addr[0]);
            end else begin
                inst_rvalid <= 1'b0;
            end
        end
    end

    initial begin
        int start;
        int limit;
        RST         = 1'b1;
        mmu_wait    = 1'b0;
        inst_rvalid = 1'b0;
        inst_roaddr = '0;
        inst_rdata  = '0;
        cyc         = 0;
        cur_wait    = 0;
        cur_lat     = 1;
        void'($urandom(32'ha504_461d));
        load_program();
        for (int t = 0; t < NUM_TESTS; t++) begin
            @(posedge CLK);
            RST <= 1'b1;
            // memory and monitor are held in reset from here
            @(posedge CLK);
            cur_wait = wait_pct[t];
            cur_lat  = max_lat[t];
            mon0.begin_test(test_name[t]);
            for (int i = 0; i < NUM_STORE; i++) begin
                mon0.add_expected(exp_addr[i], exp_data[i]);
            end
            repeat (2) @(posedge CLK);
            RST <= 1'b0;
            start = cyc;
            limit = PROG_LEN * (max_lat[t] + 1) * 4 + 50;
            while (store_seen < NUM_STORE && (cyc - start) < limit) begin
                @(negedge CLK);
            end
            if (store_seen < NUM_STORE) begin
                $display("timeout in test %s after %0d cycles, %0d of %0d stores seen",
                         test_name[t], limit, store_seen, NUM_STORE);
                mon0.end_test();
                mon0.report_totals();
                $display("Something failed");
                $finish;
            end else begin
                // catch stray stores after the last one
                repeat (10) @(negedge CLK);
                mon0.end_test();
            end
        end
        mon0.report_totals();
        if (error_count == 0 && dut0.chk0.fail_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb_monitor.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_monitor import core_pkg::*; (
    input  wire             CLK,
    input  wire             RST,
    input  wire             mmu_wait,
    input  wire             inst_rden,
    input  wire [XLEN-1:0]  inst_riaddr,
    input  wire             data_wren,
    input  wire [XLEN-1:0]  data_waddr,
    input  wire [XLEN-1:0]  data_wdata,
    output int              store_seen,
    output int              error_count
);

    logic [XLEN-1:0] exp_addr[$];
    logic [XLEN-1:0] exp_data[$];
    string           test_name;
    int              test_errors;
    int              store_errors;
    int              end_errors;
    int              tests_run;
    int              tests_failed;
    logic            first_req;

    initial begin
        store_seen   = 0;
        test_errors  = 0;
        store_errors = 0;
        end_errors   = 0;
        tests_run    = 0;
        tests_failed = 0;
        first_req    = 1'b0;
    end

    assign error_count = store_errors + end_errors;

    task automatic begin_test(input string name);
        test_name = name;
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic add_expected(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic end_test();
        int missing;
        missing = exp_addr.size() - store_seen;
        tests_run++;
        if (missing > 0) begin
            $display("test %s: %0d expected stores never appeared", test_name, missing);
            end_errors++;
        end
        if (test_errors == 0 && missing <= 0) begin
            $display("test %s: passed, %0d stores", test_name, store_seen);
        end else begin
            $display("test %s: failed, %0d errors", test_name, test_errors);
            tests_failed++;
        end
    endtask

    task automatic report_totals();
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
    endtask

    always @(posedge CLK) begin
        if (RST) begin
            store_seen  = 0;
            test_errors = 0;
            first_req   = 1'b0;
        end else begin
            // very first fetch after reset
            if (inst_rden && !first_req) begin
                first_req = 1'b1;
                if (inst_riaddr !== START_ADDR) begin
                    $display("MISMATCH %0t inst_riaddr exp %h got %h",
                             $time, START_ADDR, inst_riaddr);
                    test_errors++;
                    store_errors++;
                end
            end
            if (data_wren && !mmu_wait) begin
                if (store_seen >= exp_addr.size()) begin
                    $display("unexpected extra store at %0t to address %h", $time, data_waddr);
                    test_errors++;
                    store_errors++;
                end else begin
                    if (data_waddr !== exp_addr[store_seen]) begin
                        $display("MISMATCH %0t data_waddr exp %h got %h",
                                 $time, exp_addr[store_seen], data_waddr);
                        test_errors++;
                        store_errors++;
                    end
                    if (data_wdata !== exp_data[store_seen]) begin
                        $display("MISMATCH %0t data_wdata exp %h got %h",
                                 $time, exp_data[store_seen], data_wdata);
                        test_errors++;
                        store_errors++;
                    end
                end
                store_seen++;
            end
        end
    end

endmodule

`default_nettype wire

/* core_chk.sv */
`timescale 1ns/1ns
`default_nettype none

module core_chk import core_pkg::*; (
    input wire             CLK,
    input wire             RST,
    input wire             mmu_wait,
    input wire             inst_rden,
    input wire [XLEN-1:0]  inst_riaddr,
    input wire             data_wren,
    input wire [XLEN-1:0]  data_waddr,
    input wire [XLEN-1:0]  data_wdata
);

    int fail_count;

    initial begin
        fail_count = 0;
    end

    wren_low_after_reset: assert property (@(posedge CLK) RST |=> !data_wren)
        else begin
            fail_count++;
            $error("data_wren high right after reset");
        end

    // the store port freezes with the pipe
    store_hold_on_wait: assert property (@(posedge CLK) disable iff (RST)
        mmu_wait |=> ($stable(data_wren) && $stable(data_waddr) && $stable(data_wdata)))
        else begin
            fail_count++;
            $error("store port changed during mmu_wait");
        end

    fetch_aligned: assert property (@(posedge CLK) disable iff (RST)
        inst_rden |-> (inst_riaddr[1:0] == 2'b00))
        else begin
            fail_count++;
            $error("unaligned instruction request");
        end

endmodule

bind core_top core_chk chk0 (.*);

`default_nettype wire

/* core_top.sv */
`timescale 1ns/1ns
`default_nettype none

module core_top import core_pkg::*; (
    input  wire              CLK,
    input  wire              RST,
    input  wire              mmu_wait,
    input  wire [XLEN-1:0]   inst_roaddr,
    input  wire              inst_rvalid,
    input  wire [XLEN-1:0]   inst_rdata,
    output logic             inst_rden,
    output logic [XLEN-1:0]  inst_riaddr,
    output logic             data_wren,
    output logic [XLEN-1:0]  data_waddr,
    output logic [XLEN-1:0]  data_wdata
);

    fetch_t                fetch_q;
    logic                  fetch_valid;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    dec_t                  dec_d;
    logic                  dec_d_valid;
    dec_t                  dec_q;
    logic                  dec_q_valid;
    res_t                  res_d;
    logic                  res_d_valid;
    res_t                  res_q;
    logic                  res_q_valid;
    redirect_t             redirect;

    fetch fetch0 (
        .CLK(CLK), .RST(RST), .mmu_wait(mmu_wait), .redirect(redirect),
        .inst_roaddr(inst_roaddr), .inst_rvalid(inst_rvalid), .inst_rdata(inst_rdata),
        .inst_rden(inst_rden), .inst_riaddr(inst_riaddr),
        .fetch_out(fetch_q), .fetch_valid(fetch_valid)
    );

    decode decode0 (
        .fetch_in(fetch_q), .fetch_valid(fetch_valid),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .dec_out(dec_d), .dec_valid(dec_d_valid)
    );

    regfile regfile0 (
        .CLK(CLK), .RST(RST), .mmu_wait(mmu_wait),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .wr(res_q), .wr_valid(res_q_valid),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    // younger instruction in decode dies on a taken jump
    stage_reg #(.payload_t(dec_t)) d2e (
        .CLK(CLK), .RST(RST), .mmu_wait(mmu_wait), .flush(redirect.taken),
        .in_data(dec_d), .in_valid(dec_d_valid),
        .out_data(dec_q), .out_valid(dec_q_valid)
    );

    exec exec0 (
        .dec_in(dec_q), .dec_valid(dec_q_valid),
        .fwd(res_q), .fwd_valid(res_q_valid),
        .res_out(res_d), .res_valid(res_d_valid), .redirect(redirect)
    );

    // the jump itself carries on to write its link register
    stage_reg #(.payload_t(res_t)) e2c (
        .CLK(CLK), .RST(RST), .mmu_wait(mmu_wait), .flush(1'b0),
        .in_data(res_d), .in_valid(res_d_valid),
        .out_data(res_q), .out_valid(res_q_valid)
    );

    assign data_wren  = res_q_valid && res_q.store_en;
    assign data_waddr = res_q.store_addr;
    assign data_wdata = res_q.store_data;

endmodule

`default_nettype wire

/* exec.sv */
`timescale 1ns/1ns
`default_nettype none

module exec import core_pkg::*; (
    input  wire dec_t    dec_in,
    input  wire          dec_valid,
    input  wire res_t    fwd,
    input  wire          fwd_valid,
    output res_t         res_out,
    output logic         res_valid,
    output redirect_t    redirect
);

    logic            fwd_rs1;
    logic            fwd_rs2;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_y;
    logic [XLEN-1:0] link;
    logic            eq;

    // older instruction in e2c has not reached the regfile yet
    assign fwd_rs1 = fwd_valid && fwd.reg_we && (fwd.rd != '0) && (fwd.rd == dec_in.rs1);
    assign fwd_rs2 = fwd_valid && fwd.reg_we && (fwd.rd != '0) && (fwd.rd == dec_in.rs2);

    assign rs1_val = fwd_rs1 ? fwd.wdata : dec_in.rs1_data;
    assign rs2_val = fwd_rs2 ? fwd.wdata : dec_in.rs2_data;
    assign op_b    = dec_in.use_imm ? dec_in.imm : rs2_val;

    always_comb begin
        case (dec_in.alu_op)
            ALU_ADD:    alu_y = rs1_val + op_b;
            ALU_SUB:    alu_y = rs1_val - op_b;
            ALU_AND:    alu_y = rs1_val & op_b;
            ALU_OR:     alu_y = rs1_val | op_b;
            ALU_XOR:    alu_y = rs1_val ^ op_b;
            ALU_PASS_B: alu_y = op_b;
            default:    alu_y = rs1_val + op_b;
        endcase
    end

    assign link = dec_in.pc + 32'd4;
    assign eq   = (rs1_val == rs2_val);

    always_comb begin
        res_out            = '0;
        res_out.reg_we     = dec_in.reg_we;
        res_out.rd         = dec_in.rd;
        res_out.wdata      = dec_in.is_jal ? link : alu_y;
        res_out.store_en   = dec_in.is_store;
        // sw address is rs1 + imm_s through the adder
        res_out.store_addr = alu_y;
        res_out.store_data = rs2_val;
    end

    assign res_valid = dec_valid;

    // branch and jump targets are both pc relative
    assign redirect.taken  = dec_valid && (dec_in.is_jal ||
                                           (dec_in.is_beq && eq) ||
                                           (dec_in.is_bne && !eq));
    assign redirect.target = dec_in.pc + dec_in.imm;

endmodule

`default_nettype wire

/* stage_reg.sv */
`timescale 1ns/1ns
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input  wire            CLK,
    input  wire            RST,
    input  wire            mmu_wait,
    input  wire            flush,
    input  wire payload_t  in_data,
    input  wire            in_valid,
    output payload_t       out_data,
    output logic           out_valid
);

    always_ff @(posedge CLK) begin
        if (RST) begin
            out_valid <= 1'b0;
        end else if (!mmu_wait) begin
            out_valid <= in_valid && !flush;
        end
    end

    // payload only moves when the pipe moves
    always_ff @(posedge CLK) begin
        if (!mmu_wait) begin
            out_data <= in_data;
        end
    end

endmodule

`default_nettype wire

/* regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module regfile import core_pkg::*; (
    input  wire                    CLK,
    input  wire                    RST,
    input  wire                    mmu_wait,
    input  wire [REG_ADDR_W-1:0]   rs1_addr,
    input  wire [REG_ADDR_W-1:0]   rs2_addr,
    input  wire res_t              wr,
    input  wire                    wr_valid,
    output logic [XLEN-1:0]        rs1_data,
    output logic [XLEN-1:0]        rs2_data
);

    logic [XLEN-1:0] regs [1:31];
    logic            we;

    // x0 is never stored
    assign we = wr_valid && wr.reg_we && (wr.rd != '0) && !mmu_wait;

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wr.rd] <= wr.wdata;
        end
    end

    // write-through for a read of the register being written
    assign rs1_data = (rs1_addr == '0) ? '0 :
                      (we && wr.rd == rs1_addr) ? wr.wdata : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 :
                      (we && wr.rd == rs2_addr) ? wr.wdata : regs[rs2_addr];

endmodule

`default_nettype wire

/* decode.sv */
`timescale 1ns/1ns
`default_nettype none

module decode import core_pkg::*; (
    input  wire fetch_t                fetch_in,
    input  wire                        fetch_valid,
    input  wire [XLEN-1:0]             rs1_data,
    input  wire [XLEN-1:0]             rs2_data,
    output logic [REG_ADDR_W-1:0]      rs1_addr,
    output logic [REG_ADDR_W-1:0]      rs2_addr,
    output dec_t                       dec_out,
    output logic                       dec_valid
);

    logic [XLEN-1:0] inst;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;

    assign inst     = fetch_in.inst;
    assign opcode   = inst[6:0];
    assign funct3   = inst[14:12];
    assign rs1_addr = inst[19:15];
    assign rs2_addr = inst[24:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    assign dec_valid = fetch_valid;

    always_comb begin
        dec_out          = '0;
        dec_out.pc       = fetch_in.pc;
        dec_out.rd       = inst[11:7];
        dec_out.rs1      = rs1_addr;
        dec_out.rs2      = rs2_addr;
        dec_out.rs1_data = rs1_data;
        dec_out.rs2_data = rs2_data;
        dec_out.alu_op   = ALU_ADD;
        case (opcode)
            OPC_LUI: begin
                dec_out.imm     = imm_u;
                dec_out.use_imm = 1'b1;
                dec_out.alu_op  = ALU_PASS_B;
                dec_out.reg_we  = 1'b1;
            end
            OPC_OP_IMM, OPC_OP: begin
                dec_out.imm     = imm_i;
                dec_out.use_imm = (opcode == OPC_OP_IMM);
                dec_out.reg_we  = 1'b1;
                case (funct3)
                    F3_ADD_SUB: begin
                        // bit 30 selects sub, register form only
                        if (opcode == OPC_OP && inst[30]) begin
                            dec_out.alu_op = ALU_SUB;
                        end
                    end
                    F3_XOR:  dec_out.alu_op = ALU_XOR;
                    F3_OR:   dec_out.alu_op = ALU_OR;
                    F3_AND:  dec_out.alu_op = ALU_AND;
                    default: dec_out.reg_we = 1'b0;
                endcase
            end
            OPC_BRANCH: begin
                dec_out.imm    = imm_b;
                dec_out.is_beq = (funct3 == F3_BEQ);
                dec_out.is_bne = (funct3 == F3_BNE);
            end
            OPC_JAL: begin
                dec_out.imm    = imm_j;
                dec_out.is_jal = 1'b1;
                dec_out.reg_we = 1'b1;
            end
            OPC_STORE: begin
                dec_out.imm      = imm_s;
                dec_out.use_imm  = 1'b1;
                dec_out.is_store = (funct3 == F3_SW);
            end
            default: begin
                // unknown opcode runs as a bubble
                dec_out.reg_we = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* fetch.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch import core_pkg::*; (
    input  wire              CLK,
    input  wire              RST,
    input  wire              mmu_wait,
    input  wire redirect_t   redirect,
    input  wire [XLEN-1:0]   inst_roaddr,
    input  wire              inst_rvalid,
    input  wire [XLEN-1:0]   inst_rdata,
    output logic             inst_rden,
    output logic [XLEN-1:0]  inst_riaddr,
    output fetch_t           fetch_out,
    output logic             fetch_valid
);

    logic [XLEN-1:0] req_pc;
    logic [XLEN-1:0] exp_pc;
    logic            rden_q;
    logic            resp_ok;

    assign inst_rden   = rden_q;
    assign inst_riaddr = req_pc;

    // only the response for the pc we wait for, never in a redirect cycle
    assign resp_ok = inst_rvalid && (inst_roaddr == exp_pc) && !redirect.taken;

    always_ff @(posedge CLK) begin
        if (RST) begin
            rden_q      <= 1'b0;
            req_pc      <= START_ADDR;
            exp_pc      <= START_ADDR;
            fetch_valid <= 1'b0;
        end else if (!mmu_wait) begin
            rden_q <= 1'b1;
            if (redirect.taken) begin
                req_pc      <= redirect.target;
                exp_pc      <= redirect.target;
                fetch_valid <= 1'b0;
            end else begin
                // request taken by memory this cycle
                if (rden_q) begin
                    req_pc <= req_pc + 32'd4;
                end
                if (resp_ok) begin
                    exp_pc <= exp_pc + 32'd4;
                end
                fetch_valid <= resp_ok;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (!mmu_wait && resp_ok) begin
            fetch_out.pc   <= exp_pc;
            fetch_out.inst <= inst_rdata;
        end
    end

endmodule

`default_nettype wire

/* core_pkg.sv */
`default_nettype none

package core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // first fetch after reset
    localparam logic [XLEN-1:0] START_ADDR = 32'h0000_0000;

    // major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    // funct3 codes of the kept instructions
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_SW      = 3'b010;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_e;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
    } fetch_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [XLEN-1:0]       rs1_data;
        logic [XLEN-1:0]       rs2_data;
        logic [XLEN-1:0]       imm;
        alu_op_e               alu_op;
        logic                  use_imm;
        logic                  reg_we;
        logic                  is_store;
        logic                  is_beq;
        logic                  is_bne;
        logic                  is_jal;
    } dec_t;

    typedef struct packed {
        logic                  reg_we;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       wdata;
        logic                  store_en;
        logic [XLEN-1:0]       store_addr;
        logic [XLEN-1:0]       store_data;
    } res_t;

    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] target;
    } redirect_t;

endpackage

`default_nettype wire
